// ==== flist.f ====
hw/lc_pkg.sv
hw/bus_pkg.sv
hw/reg_bus_if.sv
hw/bus_arbiter.sv
hw/trigger_decoder.sv
hw/power_sequencer.sv
hw/lc_signal_shim.sv
hw/lc_env_top.sv
test/tb_lc_env.sv

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
    import bus_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              host_req_i,
    input  wire bus_op_t           host_op_i,
    input  wire logic [ADDR_W-1:0] host_addr_i,
    input  wire logic [DATA_W-1:0] host_wdata_i,
    output      logic              host_rsp_valid_o,
    output      logic [DATA_W-1:0] host_rdata_o,
    input  wire logic              dbg_req_i,
    input  wire bus_op_t           dbg_op_i,
    input  wire logic [ADDR_W-1:0] dbg_addr_i,
    input  wire logic [DATA_W-1:0] dbg_wdata_i,
    output      logic              dbg_rsp_valid_o,
    output      logic [DATA_W-1:0] dbg_rdata_o,
    reg_bus_if.arbiter             bus
);

    localparam int HOST = 0;
    localparam int DBG  = 1;

    logic [1:0]        req_in;
    logic [1:0]        cand;
    logic [1:0]        grant;
    logic [1:0]        pend_q;
    logic [1:0]        pend_set;
    bus_op_t           op_in [2];
    bus_op_t           cand_op [2];
    bus_op_t           pend_op_q [2];
    logic [ADDR_W-1:0] addr_in [2];
    logic [ADDR_W-1:0] cand_addr [2];
    logic [ADDR_W-1:0] pend_addr_q [2];
    logic [DATA_W-1:0] wdata_in [2];
    logic [DATA_W-1:0] cand_wdata [2];
    logic [DATA_W-1:0] pend_wdata_q [2];
    logic              sel;
    logic              favor_dbg_q;
    logic              owner_q;
    logic              rsp_owner_q;

    assign req_in         = {dbg_req_i, host_req_i};
    assign op_in[HOST]    = host_op_i;
    assign op_in[DBG]     = dbg_op_i;
    assign addr_in[HOST]  = host_addr_i;
    assign addr_in[DBG]   = dbg_addr_i;
    assign wdata_in[HOST] = host_wdata_i;
    assign wdata_in[DBG]  = dbg_wdata_i;

    // A parked request takes the place of the live one
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            cand[p]       = pend_q[p] | req_in[p];
            cand_op[p]    = pend_q[p] ? pend_op_q[p] : op_in[p];
            cand_addr[p]  = pend_q[p] ? pend_addr_q[p] : addr_in[p];
            cand_wdata[p] = pend_q[p] ? pend_wdata_q[p] : wdata_in[p];
        end
    end

    // --------------------------------------------------
    // Round-robin grant
    // --------------------------------------------------
    always_comb begin
        if (&cand) begin
            grant = favor_dbg_q ? 2'b10 : 2'b01;
        end else begin
            grant = cand;
        end
        // Losing live requests get parked
        pend_set = cand & ~grant & ~pend_q;
    end

    assign sel = grant[DBG];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bus.strb    <= 1'b0;
            pend_q      <= 2'b00;
            favor_dbg_q <= 1'b0;
            owner_q     <= 1'b0;
            rsp_owner_q <= 1'b0;
        end else begin
            bus.strb    <= |grant;
            pend_q      <= cand & ~grant;
            owner_q     <= sel;
            rsp_owner_q <= owner_q;
            if (&cand) begin
                favor_dbg_q <= ~favor_dbg_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|grant) begin
            bus.op    <= cand_op[sel];
            bus.addr  <= cand_addr[sel];
            bus.wdata <= cand_wdata[sel];
        end
        for (int p = 0; p < 2; p++) begin
            if (pend_set[p]) begin
                pend_op_q[p]    <= op_in[p];
                pend_addr_q[p]  <= addr_in[p];
                pend_wdata_q[p] <= wdata_in[p];
            end
        end
    end

    // Response goes back to whoever owned the read
    assign host_rsp_valid_o = bus.rsp_valid & ~rsp_owner_q;
    assign dbg_rsp_valid_o  = bus.rsp_valid & rsp_owner_q;
    assign host_rdata_o     = bus.rdata;
    assign dbg_rdata_o      = bus.rdata;

endmodule

`default_nettype wire

// ==== hw/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef enum logic {
        RD = 1'b0,
        WR = 1'b1
    } bus_op_t;

    // --------------------------------------------------
    // Register map
    // --------------------------------------------------
    localparam logic [ADDR_W-1:0] ADDR_STATUS     = 32'h7000_0040;
    // Reads of these two act as triggers
    localparam logic [ADDR_W-1:0] ADDR_TRIG_POWER = 32'h7000_0044;
    localparam logic [ADDR_W-1:0] ADDR_TRIG_RMA   = 32'h7000_0048;

endpackage

`default_nettype wire

// ==== hw/lc_env_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc_env_top
    import bus_pkg::*;
    import lc_pkg::*;
#(
    parameter int           WARMUP_CYCLES = 500,
    parameter int           TRIG_DELAY    = 20,
    parameter logic [127:0] TEST_TOKEN    = 128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    // Host master
    input  wire logic              host_req_i,
    input  wire bus_op_t           host_op_i,
    input  wire logic [ADDR_W-1:0] host_addr_i,
    input  wire logic [DATA_W-1:0] host_wdata_i,
    output      logic              host_rsp_valid_o,
    output      logic [DATA_W-1:0] host_rdata_o,
    // Debug master
    input  wire logic              dbg_req_i,
    input  wire bus_op_t           dbg_op_i,
    input  wire logic [ADDR_W-1:0] dbg_addr_i,
    input  wire logic [DATA_W-1:0] dbg_wdata_i,
    output      logic              dbg_rsp_valid_o,
    output      logic [DATA_W-1:0] dbg_rdata_o,
    // Power and lifecycle
    input  wire logic              pwrgood_i,
    output      logic              lc_init_o,
    output      logic              ctrl_rst_n_o,
    output      logic              rma_strap_o,
    // OTP, flash, alerts and clock manager
    input  wire lc_otp_data_t      otp_data_i,
    output lc_otp_data_t           otp_data_o,
    input  wire logic [3:0]        flash_rma_req_i,
    output      logic [7:0]        flash_rma_ack_o,
    input  wire logic [2:0]        alerts_i,
    output      logic              esc_scrap0_o,
    output      logic              esc_scrap1_o,
    input  wire lc_tx_t            clk_byp_req_i,
    output lc_tx_t                 clk_byp_ack_o
);

    logic           trig_power;
    logic           seq_busy;
    logic           esc;
    pwr_seq_state_t seq_state;

    reg_bus_if bus_if_i ();

    bus_arbiter arb_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .host_req_i       (host_req_i),
        .host_op_i        (host_op_i),
        .host_addr_i      (host_addr_i),
        .host_wdata_i     (host_wdata_i),
        .host_rsp_valid_o (host_rsp_valid_o),
        .host_rdata_o     (host_rdata_o),
        .dbg_req_i        (dbg_req_i),
        .dbg_op_i         (dbg_op_i),
        .dbg_addr_i       (dbg_addr_i),
        .dbg_wdata_i      (dbg_wdata_i),
        .dbg_rsp_valid_o  (dbg_rsp_valid_o),
        .dbg_rdata_o      (dbg_rdata_o),
        .bus              (bus_if_i.arbiter)
    );

    trigger_decoder dec_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .bus          (bus_if_i.decoder),
        .seq_busy_i   (seq_busy),
        .lc_init_i    (lc_init_o),
        .seq_state_i  (seq_state),
        .esc_i        (esc),
        .trig_power_o (trig_power),
        .rma_strap_o  (rma_strap_o)
    );

    power_sequencer #(
        .WARMUP_CYCLES (WARMUP_CYCLES),
        .TRIG_DELAY    (TRIG_DELAY)
    ) seq_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .pwrgood_i    (pwrgood_i),
        .trig_power_i (trig_power),
        .busy_o       (seq_busy),
        .lc_init_o    (lc_init_o),
        .ctrl_rst_n_o (ctrl_rst_n_o),
        .state_o      (seq_state)
    );

    lc_signal_shim #(
        .TEST_TOKEN (TEST_TOKEN)
    ) shim_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .otp_data_i      (otp_data_i),
        .otp_data_o      (otp_data_o),
        .flash_rma_req_i (flash_rma_req_i),
        .flash_rma_ack_o (flash_rma_ack_o),
        .alerts_i        (alerts_i),
        .esc_scrap0_o    (esc_scrap0_o),
        .esc_scrap1_o    (esc_scrap1_o),
        .esc_o           (esc),
        .clk_byp_req_i   (clk_byp_req_i),
        .clk_byp_ack_o   (clk_byp_ack_o)
    );

endmodule

`default_nettype wire

// ==== hw/lc_pkg.sv ====
`default_nettype none

package lc_pkg;

    // Multi-bit lifecycle signal, only two legal encodings
    typedef enum logic [3:0] {
        On  = 4'b1010,
        Off = 4'b0101
    } lc_tx_t;

    // Power sequencer states, also reported in the status register
    typedef enum logic [1:0] {
        WARMUP  = 2'd0,
        READY   = 2'd1,
        RESTART = 2'd2
    } pwr_seq_state_t;

    typedef struct packed {
        logic           valid;
        logic           error;
        logic [7:0]     state;
        logic [7:0]     count;
        lc_tx_t         secrets_valid;
        lc_tx_t         test_tokens_valid;
        lc_tx_t         rma_token_valid;
        logic [127:0]   test_unlock_token;
        logic [127:0]   test_exit_token;
        logic [127:0]   rma_token;
    } lc_otp_data_t;

    // Flash RMA handshake codes
    localparam logic [3:0] RMA_REQ_CODE = 4'h5;
    localparam logic [7:0] RMA_ACK_YES  = 8'h55;
    localparam logic [7:0] RMA_ACK_NO   = 8'hAA;

endpackage

`default_nettype wire

// ==== hw/lc_signal_shim.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc_signal_shim
    import lc_pkg::*;
#(
    parameter logic [127:0] TEST_TOKEN = '0
) (
    input  wire logic         clk,
    input  wire logic         reset_n,
    input  wire lc_otp_data_t otp_data_i,
    output lc_otp_data_t      otp_data_o,
    input  wire logic [3:0]   flash_rma_req_i,
    output      logic [7:0]   flash_rma_ack_o,
    input  wire logic [2:0]   alerts_i,
    output      logic         esc_scrap0_o,
    output      logic         esc_scrap1_o,
    output      logic         esc_o,
    input  wire lc_tx_t       clk_byp_req_i,
    output lc_tx_t            clk_byp_ack_o
);

    logic esc;

    // OTP data with tokens forced valid
    always_comb begin
        otp_data_o                   = otp_data_i;
        otp_data_o.test_tokens_valid = On;
        otp_data_o.rma_token_valid   = On;
        otp_data_o.test_unlock_token = TEST_TOKEN;
        otp_data_o.test_exit_token   = TEST_TOKEN;
        otp_data_o.rma_token         = TEST_TOKEN;
    end

    assign flash_rma_ack_o = (flash_rma_req_i == RMA_REQ_CODE) ? RMA_ACK_YES : RMA_ACK_NO;

    // Any alert escalates
    assign esc          = |alerts_i;
    assign esc_scrap0_o = esc;
    assign esc_scrap1_o = esc;
    assign esc_o        = esc;

    // --------------------------------------------------
    // Clock bypass responder
    // --------------------------------------------------
    // Held request gives On, Off, On, ...
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            clk_byp_ack_o <= Off;
        end else if (clk_byp_req_i == On && clk_byp_ack_o == Off) begin
            clk_byp_ack_o <= On;
        end else begin
            clk_byp_ack_o <= Off;
        end
    end

endmodule

`default_nettype wire

// ==== hw/power_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module power_sequencer
    import lc_pkg::*;
#(
    parameter int WARMUP_CYCLES = 500,
    parameter int TRIG_DELAY    = 20
) (
    input  wire logic     clk,
    input  wire logic     reset_n,
    input  wire logic     pwrgood_i,
    input  wire logic     trig_power_i,
    output      logic     busy_o,
    output      logic     lc_init_o,
    output      logic     ctrl_rst_n_o,
    output pwr_seq_state_t state_o
);

    localparam int CNT_W = $clog2(WARMUP_CYCLES + 1);

    logic [TRIG_DELAY-1:0] dly_q;
    logic [CNT_W-1:0]      cnt_q;
    logic                  cnt_done;
    logic                  trig_late;
    pwr_seq_state_t        state_q;

    assign trig_late = dly_q[TRIG_DELAY-1];
    assign cnt_done  = (cnt_q == CNT_W'(WARMUP_CYCLES - 1));

    // --------------------------------------------------
    // Trigger delay line and init/reset FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dly_q        <= '0;
            cnt_q        <= '0;
            state_q      <= WARMUP;
            ctrl_rst_n_o <= 1'b1;
        end else if (pwrgood_i) begin
            dly_q <= {dly_q[TRIG_DELAY-2:0], trig_power_i};
            case (state_q)
                WARMUP, RESTART: begin
                    // The restart cycle is the first cycle of the count
                    if (cnt_done) begin
                        state_q      <= READY;
                        ctrl_rst_n_o <= 1'b1;
                    end else begin
                        cnt_q   <= cnt_q + 1'b1;
                        state_q <= WARMUP;
                    end
                end
                READY: begin
                    if (trig_late) begin
                        state_q      <= RESTART;
                        cnt_q        <= '0;
                        ctrl_rst_n_o <= 1'b0;
                    end
                end
                default: begin
                    state_q <= WARMUP;
                    cnt_q   <= '0;
                end
            endcase
        end
    end

    assign lc_init_o = (state_q == READY);
    assign state_o   = state_q;

    // Pulse in flight counts as busy
    assign busy_o = (|dly_q) || (state_q != READY);

endmodule

`default_nettype wire

// ==== hw/reg_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if
    import bus_pkg::*;
();

    // Request side, valid only while strb is high
    logic              strb;
    bus_op_t           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // Response side, one cycle after a read strobe
    logic              rsp_valid;
    logic [DATA_W-1:0] rdata;

    modport arbiter (
        output strb, op, addr, wdata,
        input  rsp_valid, rdata
    );

    modport decoder (
        input  strb, op, addr, wdata,
        output rsp_valid, rdata
    );

endinterface

`default_nettype wire

// ==== hw/trigger_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module trigger_decoder
    import bus_pkg::*;
    import lc_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset_n,
    reg_bus_if.decoder          bus,
    input  wire logic           seq_busy_i,
    input  wire logic           lc_init_i,
    input  wire pwr_seq_state_t seq_state_i,
    input  wire logic           esc_i,
    output      logic           trig_power_o,
    output      logic           rma_strap_o
);

    logic              rd_strb;
    logic              hit_power;
    logic              hit_rma;
    logic [DATA_W-1:0] rd_value;

    // Writes land here too but change nothing
    assign rd_strb   = bus.strb && (bus.op == RD);
    assign hit_power = rd_strb && (bus.addr == ADDR_TRIG_POWER);
    assign hit_rma   = rd_strb && (bus.addr == ADDR_TRIG_RMA);

    always_comb begin
        rd_value = '0;
        if (bus.addr == ADDR_STATUS) begin
            rd_value[0]   = rma_strap_o;
            rd_value[1]   = lc_init_i;
            rd_value[2]   = esc_i;
            rd_value[5:4] = seq_state_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bus.rsp_valid <= 1'b0;
            trig_power_o  <= 1'b0;
            rma_strap_o   <= 1'b0;
        end else begin
            bus.rsp_valid <= rd_strb;
            // Drop the trigger while a restart is already on its way
            trig_power_o  <= hit_power && !seq_busy_i && !trig_power_o;
            if (hit_rma) begin
                rma_strap_o <= ~rma_strap_o;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_strb) begin
            bus.rdata <= rd_value;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the lifecycle environment testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_lc_env -o tb_lc_env -f flist.f

out=$(./obj_dir/tb_lc_env 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Finished with no errors$"; then
    exit 0
fi
exit 1

// ==== test/tb_lc_env.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lc_env
    import bus_pkg::*;
    import lc_pkg::*;
();

    localparam int                WARMUP        = 40;
    localparam int                DELAY         = 20;
    localparam logic [127:0]      TOKEN         = 128'h3c5a_96e1_0f87_d2b4_6a19_e5c3_7b20_48fd;
    localparam logic [ADDR_W-1:0] ADDR_UNMAPPED = 32'h7000_004c;
    // Several times the length of all test phases together
    localparam int                CYCLE_LIMIT   = 4000;

    logic              clk;
    logic              reset_n;
    logic              host_req_i;
    bus_op_t           host_op_i;
    logic [ADDR_W-1:0] host_addr_i;
    logic [DATA_W-1:0] host_wdata_i;
    logic              host_rsp_valid_o;
    logic [DATA_W-1:0] host_rdata_o;
    logic              dbg_req_i;
    bus_op_t           dbg_op_i;
    logic [ADDR_W-1:0] dbg_addr_i;
    logic [DATA_W-1:0] dbg_wdata_i;
    logic              dbg_rsp_valid_o;
    logic [DATA_W-1:0] dbg_rdata_o;
    logic              pwrgood_i;
    logic              lc_init_o;
    logic              ctrl_rst_n_o;
    logic              rma_strap_o;
    lc_otp_data_t      otp_data_i;
    lc_otp_data_t      otp_data_o;
    logic [3:0]        flash_rma_req_i;
    logic [7:0]        flash_rma_ack_o;
    logic [2:0]        alerts_i;
    logic              esc_scrap0_o;
    logic              esc_scrap1_o;
    lc_tx_t            clk_byp_req_i;
    lc_tx_t            clk_byp_ack_o;

    int                cyc = 0;
    logic [15:0]       lfsr;
    logic              model_strap;
    logic              model_init;
    // Expected read data and issue cycle per port in bus order
    logic [31:0]       host_exp_q [$];
    int                host_cyc_q [$];
    logic [31:0]       dbg_exp_q [$];
    int                dbg_cyc_q [$];

    lc_env_top #(
        .WARMUP_CYCLES (WARMUP),
        .TRIG_DELAY    (DELAY),
        .TEST_TOKEN    (TOKEN)
    ) dut_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .host_req_i       (host_req_i),
        .host_op_i        (host_op_i),
        .host_addr_i      (host_addr_i),
        .host_wdata_i     (host_wdata_i),
        .host_rsp_valid_o (host_rsp_valid_o),
        .host_rdata_o     (host_rdata_o),
        .dbg_req_i        (dbg_req_i),
        .dbg_op_i         (dbg_op_i),
        .dbg_addr_i       (dbg_addr_i),
        .dbg_wdata_i      (dbg_wdata_i),
        .dbg_rsp_valid_o  (dbg_rsp_valid_o),
        .dbg_rdata_o      (dbg_rdata_o),
        .pwrgood_i        (pwrgood_i),
        .lc_init_o        (lc_init_o),
        .ctrl_rst_n_o     (ctrl_rst_n_o),
        .rma_strap_o      (rma_strap_o),
        .otp_data_i       (otp_data_i),
        .otp_data_o       (otp_data_o),
        .flash_rma_req_i  (flash_rma_req_i),
        .flash_rma_ack_o  (flash_rma_ack_o),
        .alerts_i         (alerts_i),
        .esc_scrap0_o     (esc_scrap0_o),
        .esc_scrap1_o     (esc_scrap1_o),
        .clk_byp_req_i    (clk_byp_req_i),
        .clk_byp_ack_o    (clk_byp_ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------------------------------------
    // Random source and reference model
    // --------------------------------------------------
    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[126:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] status_ref(input logic strap, input logic init,
                                               input logic esc, input pwr_seq_state_t st);
        logic [31:0] v;
        v      = '0;
        v[0]   = strap;
        v[1]   = init;
        v[2]   = esc;
        v[5:4] = st;
        return v;
    endfunction

    function automatic lc_otp_data_t otp_ref(input lc_otp_data_t d);
        lc_otp_data_t e;
        e                   = d;
        e.test_tokens_valid = On;
        e.rma_token_valid   = On;
        e.test_unlock_token = TOKEN;
        e.test_exit_token   = TOKEN;
        e.rma_token         = TOKEN;
        return e;
    endfunction

    // lc_init_o and ctrl_rst_n_o k cycles after a power trigger is driven
    function automatic logic init_ref(input int k);
        return !(k >= DELAY + 3 && k < DELAY + 3 + WARMUP);
    endfunction

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic compare_value(input logic [511:0] got, input logic [511:0] exp,
                                 input string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0d ns: %s is %0h, expected %0h",
                                $time, what, got, exp));
        end
    endtask

    task automatic take_response(input logic is_dbg, input logic [31:0] data);
        logic [31:0] exp;
        int          issued;
        string       port;
        if (is_dbg) begin
            port = "debug";
        end else begin
            port = "host";
        end
        if (is_dbg ? (dbg_exp_q.size() == 0) : (host_exp_q.size() == 0)) begin
            abort_run({"Response on the ", port, " port with no read outstanding"});
        end else begin
            if (is_dbg) begin
                exp    = dbg_exp_q.pop_front();
                issued = dbg_cyc_q.pop_front();
            end else begin
                exp    = host_exp_q.pop_front();
                issued = host_cyc_q.pop_front();
            end
            compare_value(512'(data), 512'(exp), {port, " read data"});
            if (cyc - issued < 2 || cyc - issued > 3) begin
                abort_run($sformatf("Read on the %s port answered after %0d cycles", port,
                                    cyc - issued));
            end
        end
    endtask

    // Compare process for bus responses
    always @(negedge clk) begin
        if (host_rsp_valid_o) begin
            take_response(1'b0, host_rdata_o);
        end
        if (dbg_rsp_valid_o) begin
            take_response(1'b1, dbg_rdata_o);
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            abort_run("The run timed out before all tests finished");
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    // One strobe from each selected port and then an idle cycle
    task automatic issue_strobes(input logic go_h, input logic go_d, input bus_op_t op,
                                 input logic [ADDR_W-1:0] addr_h,
                                 input logic [ADDR_W-1:0] addr_d,
                                 input logic [31:0] exp_h, input logic [31:0] exp_d);
        host_req_i   = go_h;
        host_op_i    = op;
        host_addr_i  = addr_h;
        host_wdata_i = 32'(rand_bits(32));
        dbg_req_i    = go_d;
        dbg_op_i     = op;
        dbg_addr_i   = addr_d;
        dbg_wdata_i  = 32'(rand_bits(32));
        if (go_h && op == RD) begin
            host_exp_q.push_back(exp_h);
            host_cyc_q.push_back(cyc);
        end
        if (go_d && op == RD) begin
            dbg_exp_q.push_back(exp_d);
            dbg_cyc_q.push_back(cyc);
        end
        @(negedge clk);
        host_req_i = 1'b0;
        dbg_req_i  = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_responses();
        while (host_exp_q.size() != 0 || dbg_exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        int                good;
        logic              pwr;
        logic [2:0]        pick;
        logic              go_h;
        logic              go_d;
        logic [ADDR_W-1:0] a_h;
        logic [ADDR_W-1:0] a_d;
        logic [31:0]       st;
        lc_otp_data_t      otp_in;
        logic [3:0]        code;
        lc_tx_t            exp_ack;

        reset_n         = 1'b0;
        host_req_i      = 1'b0;
        host_op_i       = RD;
        host_addr_i     = '0;
        host_wdata_i    = '0;
        dbg_req_i       = 1'b0;
        dbg_op_i        = RD;
        dbg_addr_i      = '0;
        dbg_wdata_i     = '0;
        pwrgood_i       = 1'b1;
        otp_data_i      = '0;
        flash_rma_req_i = '0;
        alerts_i        = '0;
        clk_byp_req_i   = Off;
        lfsr            = 16'd47;
        model_strap     = 1'b0;
        model_init      = 1'b0;

        repeat (10) @(negedge clk);
        reset_n = 1'b1;

        // Warm-up with power dropped for 7 cycles on the way
        good = 0;
        for (int step = 0; good < WARMUP + 4; step++) begin
            compare_value(512'(lc_init_o), 512'(good >= WARMUP), "lc_init_o during warm-up");
            compare_value(512'(ctrl_rst_n_o), 512'(1'b1), "ctrl_rst_n_o during warm-up");
            pwr       = !(step >= 12 && step < 19);
            pwrgood_i = pwr;
            @(posedge clk);
            if (pwr) begin
                good++;
            end
            @(negedge clk);
        end
        model_init = 1'b1;

        // Status reads, RMA triggers and ignored writes
        for (int i = 0; i < 48; i++) begin
            if (i % 8 == 0) begin
                wait_responses();
                alerts_i = 3'(rand_bits(3));
            end
            pick = 3'(rand_bits(3));
            go_h = 1'(rand_bits(1));
            if (pick == 3'd0) begin
                issue_strobes(go_h, !go_h, RD, ADDR_TRIG_RMA, ADDR_TRIG_RMA, '0, '0);
                wait_responses();
                model_strap = ~model_strap;
                compare_value(512'(rma_strap_o), 512'(model_strap), "rma_strap_o after read");
            end else if (pick == 3'd1) begin
                issue_strobes(go_h, !go_h, WR, ADDR_TRIG_RMA, ADDR_TRIG_RMA, '0, '0);
                repeat (2) @(negedge clk);
                compare_value(512'(rma_strap_o), 512'(model_strap), "rma_strap_o after write");
            end else begin
                go_d = 1'(rand_bits(1)) | !go_h;
                a_h  = (2'(rand_bits(2)) == 2'd0) ? ADDR_UNMAPPED : ADDR_STATUS;
                a_d  = (2'(rand_bits(2)) == 2'd0) ? ADDR_UNMAPPED : ADDR_STATUS;
                st   = status_ref(model_strap, model_init, |alerts_i, READY);
                issue_strobes(go_h, go_d, RD, a_h, a_d,
                              (a_h == ADDR_STATUS) ? st : 32'd0,
                              (a_d == ADDR_STATUS) ? st : 32'd0);
            end
        end
        wait_responses();

        // Power restart plus two triggers that must be ignored
        for (int k = 0; k <= 2 * DELAY + WARMUP + 12; k++) begin
            compare_value(512'(lc_init_o), 512'(init_ref(k)), "lc_init_o around restart");
            compare_value(512'(ctrl_rst_n_o), 512'(init_ref(k)), "ctrl_rst_n_o around restart");
            if (k == 0 || k == DELAY + WARMUP - 2) begin
                host_req_i  = 1'b1;
                host_op_i   = RD;
                host_addr_i = ADDR_TRIG_POWER;
                host_exp_q.push_back('0);
                host_cyc_q.push_back(cyc);
            end else if (k == 8) begin
                // Pulse still in the delay line
                dbg_req_i  = 1'b1;
                dbg_op_i   = RD;
                dbg_addr_i = ADDR_TRIG_POWER;
                dbg_exp_q.push_back('0);
                dbg_cyc_q.push_back(cyc);
            end else begin
                host_req_i = 1'b0;
                dbg_req_i  = 1'b0;
            end
            @(negedge clk);
        end
        wait_responses();

        // OTP overrides, flash acknowledge and escalation
        for (int i = 0; i < 40; i++) begin
            otp_in = lc_otp_data_t'({rand_bits(128), rand_bits(128), rand_bits(128),
                                     30'(rand_bits(30))});
            code   = (2'(rand_bits(2)) == 2'd0) ? RMA_REQ_CODE : 4'(rand_bits(4));
            otp_data_i      = otp_in;
            flash_rma_req_i = code;
            alerts_i        = 3'(rand_bits(3));
            @(negedge clk);
            compare_value(512'(otp_data_o), 512'(otp_ref(otp_in)), "otp_data_o");
            compare_value(512'(flash_rma_ack_o),
                          512'((code == RMA_REQ_CODE) ? 8'h55 : 8'haa), "flash_rma_ack_o");
            compare_value(512'(esc_scrap0_o), 512'(|alerts_i), "esc_scrap0_o");
            compare_value(512'(esc_scrap1_o), 512'(|alerts_i), "esc_scrap1_o");
        end

        // Clock bypass with request held On then Off
        exp_ack = Off;
        compare_value(512'(clk_byp_ack_o), 512'(exp_ack), "clk_byp_ack_o idle");
        for (int i = 0; i < 24; i++) begin
            clk_byp_req_i = (i < 14) ? On : Off;
            @(negedge clk);
            // Held request answers on every even cycle of the hold
            exp_ack = (i < 14 && i % 2 == 0) ? On : Off;
            compare_value(512'(clk_byp_ack_o), 512'(exp_ack), "clk_byp_ack_o");
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
